// ==== files.f ====
+incdir+testbench
hw/uno_pkg.sv
hw/hand_store.sv
hw/hand_cursor.sv
hw/turn_ctrl.sv
hw/uno_player.sv
testbench/tb_uno_player.sv

// ==== hw/hand_cursor.sv ====
`timescale 1ns/100ps
`default_nettype none

module hand_cursor (
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  logic               i_left,
    input  logic               i_right,
    input  logic               i_color_mode,
    input  uno_pkg::count_t    i_count,
    output uno_pkg::hand_idx_t o_index
);

    typedef enum logic [1:0] {
        CUR_STAY,
        CUR_LEFT,     // waiting for left release
        CUR_RIGHT,    // waiting for right release
        CUR_COLOR
    } cur_state_e;

    cur_state_e         state;
    cur_state_e         state_n;
    uno_pkg::hand_idx_t index_n;
    uno_pkg::hand_idx_t last;

    assign last = i_count - 4'd1;   // rightmost card, draw slot when empty

    always_comb begin
        state_n = state;
        index_n = o_index;
        case (state)
            CUR_STAY: begin
                if (i_color_mode) begin
                    index_n = '0;
                    state_n = CUR_COLOR;
                end else if (i_left) begin
                    if (o_index == 4'd0) begin
                        index_n = uno_pkg::DRAW_SLOT;
                    end else if (o_index == uno_pkg::DRAW_SLOT) begin
                        index_n = last;
                    end else begin
                        index_n = o_index - 4'd1;
                    end
                    state_n = CUR_LEFT;
                end else if (i_right) begin
                    if (o_index == uno_pkg::DRAW_SLOT) begin
                        index_n = '0;
                    end else if (o_index == last) begin
                        index_n = uno_pkg::DRAW_SLOT;
                    end else begin
                        index_n = o_index + 4'd1;
                    end
                    state_n = CUR_RIGHT;
                end else if (o_index != uno_pkg::DRAW_SLOT && o_index >= i_count) begin
                    index_n = last;   // hand shrank under the cursor
                end
            end
            CUR_LEFT: begin
                if (!i_left) begin
                    state_n = i_color_mode ? CUR_COLOR : CUR_STAY;
                end
            end
            CUR_RIGHT: begin
                if (!i_right) begin
                    state_n = i_color_mode ? CUR_COLOR : CUR_STAY;
                end
            end
            default: begin
                if (!i_color_mode) begin
                    index_n = '0;
                    state_n = CUR_STAY;
                end else if (i_left) begin
                    index_n = (o_index == 4'd0) ? 4'd3 : o_index - 4'd1;
                    state_n = CUR_LEFT;
                end else if (i_right) begin
                    index_n = (o_index == 4'd3) ? 4'd0 : o_index + 4'd1;
                    state_n = CUR_RIGHT;
                end
            end
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state   <= CUR_STAY;
            o_index <= '0;
        end else begin
            state   <= state_n;
            o_index <= index_n;
        end
    end

endmodule

`default_nettype wire

// ==== hw/hand_store.sv ====
`timescale 1ns/100ps
`default_nettype none

module hand_store (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  uno_pkg::store_cmd_t i_cmd,
    output uno_pkg::card_t      o_hands [uno_pkg::HAND_MAX],
    output uno_pkg::count_t     o_count
);

    uno_pkg::card_t  col_bin  [4][uno_pkg::HAND_MAX];
    uno_pkg::card_t  wild_bin [2][uno_pkg::WILD_MAX];   // wild, wild four
    uno_pkg::count_t cnt      [6];
    uno_pkg::count_t base     [7];   // running sums, base[6] is the total
    uno_pkg::card_t  view     [uno_pkg::HAND_MAX];
    uno_pkg::count_t rm_off;
    logic [2:0]      ins_bin;
    logic [2:0]      rm_bin;

    always_comb begin
        base[0] = '0;
        for (int b = 0; b < 6; b++) begin
            base[b+1] = base[b] + cnt[b];
        end
    end

    // wild values go to their own bins whatever the colour field says
    always_comb begin
        case (uno_pkg::color_e'(i_cmd.card[5:4]))
            uno_pkg::RED:    ins_bin = 3'd0;
            uno_pkg::YELLOW: ins_bin = 3'd1;
            uno_pkg::GREEN:  ins_bin = 3'd2;
            default:         ins_bin = 3'd3;
        endcase
        if (i_cmd.card[3:0] == uno_pkg::VAL_WILD) begin
            ins_bin = 3'd4;
        end else if (i_cmd.card[3:0] == uno_pkg::VAL_WILD_FOUR) begin
            ins_bin = 3'd5;
        end
    end

    // hand index to bin and offset
    always_comb begin
        rm_bin = 3'd0;
        rm_off = '0;
        for (int b = 0; b < 6; b++) begin
            if (i_cmd.idx >= base[b] && i_cmd.idx < base[b+1]) begin
                rm_bin = 3'(b);
                rm_off = i_cmd.idx - base[b];
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_cmd.insert) begin
            if (ins_bin < 3'd4) begin
                col_bin[ins_bin[1:0]][cnt[ins_bin]] <= i_cmd.card;
            end else begin
                wild_bin[ins_bin[0]][cnt[ins_bin][1:0]] <= i_cmd.card;
            end
        end else if (i_cmd.remove) begin
            for (int k = 0; k < uno_pkg::HAND_MAX - 1; k++) begin
                if (rm_bin < 3'd4 && uno_pkg::count_t'(k) >= rm_off) begin
                    col_bin[rm_bin[1:0]][k] <= col_bin[rm_bin[1:0]][k+1];
                end
            end
            for (int k = 0; k < uno_pkg::WILD_MAX - 1; k++) begin
                if (rm_bin >= 3'd4 && uno_pkg::count_t'(k) >= rm_off) begin
                    wild_bin[rm_bin[0]][k] <= wild_bin[rm_bin[0]][k+1];
                end
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int b = 0; b < 6; b++) begin
                cnt[b] <= '0;
            end
        end else if (i_cmd.insert) begin
            cnt[ins_bin] <= cnt[ins_bin] + 4'd1;
        end else if (i_cmd.remove) begin
            cnt[rm_bin] <= cnt[rm_bin] - 4'd1;
        end
    end

    // concatenate the bins in colour order, pad the tail
    always_comb begin
        uno_pkg::count_t off;
        off = '0;
        for (int s = 0; s < uno_pkg::HAND_MAX; s++) begin
            view[s] = uno_pkg::EMPTY_CARD;
            for (int b = 0; b < 6; b++) begin
                if (uno_pkg::hand_idx_t'(s) >= base[b] && uno_pkg::hand_idx_t'(s) < base[b+1]) begin
                    off = uno_pkg::hand_idx_t'(s) - base[b];
                    if (b < 4) begin
                        view[s] = col_bin[b][off];
                    end else begin
                        view[s] = wild_bin[b-4][off[1:0]];
                    end
                end
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int s = 0; s < uno_pkg::HAND_MAX; s++) begin
                o_hands[s] <= uno_pkg::EMPTY_CARD;
            end
            o_count <= '0;
        end else begin
            o_hands <= view;
            o_count <= base[6];
        end
    end

    // the controller must never overfill the hand
    a_no_overflow: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_cmd.insert |-> base[6] < uno_pkg::count_t'(uno_pkg::HAND_MAX));

    a_remove_in_hand: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_cmd.remove |-> i_cmd.idx < base[6]);

endmodule

`default_nettype wire

// ==== hw/turn_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module turn_ctrl (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  uno_pkg::turn_req_t  i_turn,
    input  uno_pkg::card_t      i_prev_card,
    input  logic                i_select,
    input  logic                i_drawn,
    input  uno_pkg::card_t      i_drawn_card,
    input  logic                i_check,
    input  uno_pkg::hand_idx_t  i_index,
    input  uno_pkg::card_t      i_hands [uno_pkg::HAND_MAX],
    input  uno_pkg::count_t     i_count,
    output uno_pkg::store_cmd_t o_cmd,
    output logic                o_color_mode,
    output logic                o_draw,
    output logic                o_out,
    output uno_pkg::card_t      o_out_card
);

    typedef enum logic [2:0] {
        TC_IDLE,
        TC_DEAL,          // initial deal and penalty draws
        TC_PLAY,
        TC_CHOOSE,        // wild colour pick
        TC_OUT,
        TC_SINGLE_DRAW,
        TC_WAIT_CHECK
    } tc_state_e;

    tc_state_e       state;
    tc_state_e       state_n;
    uno_pkg::count_t draw_left;
    uno_pkg::count_t draw_left_n;
    uno_pkg::card_t  out_card_n;
    uno_pkg::card_t  sel_card;
    logic            has_card;
    logic            is_wild;
    logic            legal;

    // slots past the count hold EMPTY_CARD, which could match a blue pile card
    assign has_card = (i_index < i_count);
    assign sel_card = has_card ? i_hands[i_index] : uno_pkg::EMPTY_CARD;
    assign is_wild  = (sel_card[3:0] == uno_pkg::VAL_WILD) ||
                      (sel_card[3:0] == uno_pkg::VAL_WILD_FOUR);
    assign legal    = (sel_card[5:4] == i_prev_card[5:4]) ||
                      (sel_card[3:0] == i_prev_card[3:0]);

    always_comb begin
        state_n     = state;
        draw_left_n = draw_left;
        out_card_n  = o_out_card;
        o_cmd       = '0;
        o_cmd.card  = i_drawn_card;
        o_cmd.idx   = i_index;
        case (state)
            TC_IDLE: begin
                if (i_turn.start) begin
                    if (i_turn.draw_two) begin
                        draw_left_n = 4'd2;
                        state_n     = TC_DEAL;
                    end else if (i_turn.draw_four) begin
                        draw_left_n = 4'd4;
                        state_n     = TC_DEAL;
                    end else begin
                        state_n = TC_PLAY;
                    end
                end else if (i_turn.init) begin
                    draw_left_n = uno_pkg::DEAL_COUNT;
                    state_n     = TC_DEAL;
                end
            end
            TC_DEAL: begin
                if (i_drawn) begin
                    o_cmd.insert = 1'b1;
                    draw_left_n  = draw_left - 4'd1;
                    if (draw_left <= 4'd1) begin
                        state_n = i_turn.start ? TC_PLAY : TC_IDLE;
                    end
                end
            end
            TC_PLAY: begin
                if (i_select) begin
                    if (i_index == uno_pkg::DRAW_SLOT) begin
                        state_n = TC_SINGLE_DRAW;
                    end else if (has_card && is_wild) begin
                        o_cmd.remove = 1'b1;
                        out_card_n   = {2'b00, sel_card[3:0]};   // colour filled in later
                        state_n      = TC_CHOOSE;
                    end else if (has_card && legal) begin
                        o_cmd.remove = 1'b1;
                        out_card_n   = sel_card;
                        state_n      = TC_OUT;
                    end
                end
            end
            TC_CHOOSE: begin
                if (i_select) begin
                    out_card_n = {uno_pkg::color_e'(i_index[1:0]), o_out_card[3:0]};
                    state_n    = TC_OUT;
                end
            end
            TC_OUT: begin
                if (i_check) begin
                    state_n = TC_IDLE;
                end
            end
            TC_SINGLE_DRAW: begin
                if (i_drawn) begin
                    o_cmd.insert = 1'b1;
                    state_n      = TC_WAIT_CHECK;
                end
            end
            default: begin
                if (i_check) begin
                    state_n = TC_IDLE;
                end
            end
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state      <= TC_IDLE;
            draw_left  <= '0;
            o_out_card <= '0;
        end else begin
            state      <= state_n;
            draw_left  <= draw_left_n;
            o_out_card <= out_card_n;
        end
    end

    assign o_out        = (state == TC_OUT);
    assign o_draw       = (state == TC_SINGLE_DRAW);
    assign o_color_mode = (state == TC_CHOOSE);

    a_out_xor_draw: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(o_out && o_draw));

endmodule

`default_nettype wire

// ==== hw/uno_pkg.sv ====
`default_nettype none

package uno_pkg;

    typedef logic [5:0] card_t;       // {colour, value}
    typedef logic [3:0] hand_idx_t;   // 15 is the draw slot
    typedef logic [3:0] count_t;

    // colour field, also the bin order of the hand view
    typedef enum logic [1:0] {
        RED    = 2'd0,
        YELLOW = 2'd1,
        GREEN  = 2'd2,
        BLUE   = 2'd3
    } color_e;

    localparam int         HAND_MAX      = 15;
    localparam int         WILD_MAX      = 4;    // per wild bin
    localparam logic [3:0] VAL_WILD      = 4'd13;
    localparam logic [3:0] VAL_WILD_FOUR = 4'd14;
    localparam card_t      EMPTY_CARD    = 6'b111111;
    localparam hand_idx_t  DRAW_SLOT     = 4'd15;
    localparam count_t     DEAL_COUNT    = 4'd7;

    // level-held by the table
    typedef struct packed {
        logic start;
        logic init;
        logic draw_two;
        logic draw_four;
    } turn_req_t;

    // one-cycle command, insert and remove never together
    typedef struct packed {
        logic      insert;
        logic      remove;
        card_t     card;    // card to insert
        hand_idx_t idx;     // hand position to remove
    } store_cmd_t;

endpackage

`default_nettype wire

// ==== hw/uno_player.sv ====
`timescale 1ns/100ps
`default_nettype none

module uno_player (
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  uno_pkg::turn_req_t i_turn,
    input  uno_pkg::card_t     i_prev_card,
    input  logic               i_left,
    input  logic               i_right,
    input  logic               i_select,
    input  logic               i_drawn,
    input  uno_pkg::card_t     i_drawn_card,
    input  logic               i_check,
    output uno_pkg::card_t     o_hands [uno_pkg::HAND_MAX],
    output uno_pkg::hand_idx_t o_index,
    output logic               o_draw,
    output logic               o_out,
    output uno_pkg::card_t     o_out_card
);

    uno_pkg::store_cmd_t store_cmd;
    uno_pkg::count_t     hand_count;
    logic                color_mode;   // cursor picks a colour instead of a card

    hand_store u_hand_store (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_cmd   (store_cmd),
        .o_hands (o_hands),
        .o_count (hand_count)
    );

    hand_cursor u_hand_cursor (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_left       (i_left),
        .i_right      (i_right),
        .i_color_mode (color_mode),
        .i_count      (hand_count),
        .o_index      (o_index)
    );

    turn_ctrl u_turn_ctrl (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_turn       (i_turn),
        .i_prev_card  (i_prev_card),
        .i_select     (i_select),
        .i_drawn      (i_drawn),
        .i_drawn_card (i_drawn_card),
        .i_check      (i_check),
        .i_index      (o_index),
        .i_hands      (o_hands),
        .i_count      (hand_count),
        .o_cmd        (store_cmd),
        .o_color_mode (color_mode),
        .o_draw       (o_draw),
        .o_out        (o_out),
        .o_out_card   (o_out_card)
    );

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module tb_uno_player -o sim_uno_player

out="$(./obj_dir/sim_uno_player)"
echo "$out"

if echo "$out" | grep -qx "STATUS: PASS"; then
    exit 0
fi
exit 1

// ==== testbench/uno_model.svh ====
`ifndef UNO_MODEL_SVH
`define UNO_MODEL_SVH

logic [31:0]        lcg_state = 32'd72549;
uno_pkg::card_t     m_hand [$];   // all bins back to back, in view order
uno_pkg::hand_idx_t m_idx = '0;
logic               m_color = 1'b0;

function automatic int lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return int'(lcg_state[30:16]);
endfunction

function automatic int rand_below(int n);
    return lcg_next() % n;
endfunction

function automatic bit is_wild(uno_pkg::card_t c);
    return (c[3:0] == uno_pkg::VAL_WILD) || (c[3:0] == uno_pkg::VAL_WILD_FOUR);
endfunction

// red, yellow, green, blue, wild, wild four
function automatic int bin_of(uno_pkg::card_t c);
    if (c[3:0] == uno_pkg::VAL_WILD) begin
        return 4;
    end
    if (c[3:0] == uno_pkg::VAL_WILD_FOUR) begin
        return 5;
    end
    return int'(c[5:4]);
endfunction

function automatic int bin_count(int b);
    int n = 0;
    foreach (m_hand[k]) begin
        if (bin_of(m_hand[k]) == b) begin
            n++;
        end
    end
    return n;
endfunction

function automatic uno_pkg::card_t random_card();
    logic [3:0] val;
    logic [1:0] col;
    col = 2'(rand_below(4));
    val = 4'(rand_below(13));
    if (rand_below(8) == 0) begin
        val = (rand_below(2) == 0) ? uno_pkg::VAL_WILD : uno_pkg::VAL_WILD_FOUR;
        col = 2'd0;
        if (bin_count(bin_of({col, val})) >= uno_pkg::WILD_MAX) begin
            val = 4'(rand_below(13));   // wild bin full
        end
    end
    return {col, val};
endfunction

function automatic bit card_legal(uno_pkg::card_t c, uno_pkg::card_t prev);
    return is_wild(c) || (c[5:4] == prev[5:4]) || (c[3:0] == prev[3:0]);
endfunction

// cursor snaps back when the hand shrinks under it
function automatic void model_clamp();
    if (!m_color && m_idx != uno_pkg::DRAW_SLOT && int'(m_idx) >= m_hand.size()) begin
        m_idx = uno_pkg::hand_idx_t'(m_hand.size() - 1);
    end
endfunction

function automatic void model_insert(uno_pkg::card_t c);
    int pos = 0;
    while (pos < m_hand.size() && bin_of(m_hand[pos]) <= bin_of(c)) begin
        pos++;
    end
    m_hand.insert(pos, c);
endfunction

function automatic void model_remove(int idx);
    m_hand.delete(idx);
    model_clamp();
endfunction

function automatic void cursor_step(bit go_left);
    int last;
    last = m_hand.size() - 1;
    if (m_color) begin
        if (go_left) begin
            m_idx = (m_idx == 4'd0) ? 4'd3 : m_idx - 4'd1;
        end else begin
            m_idx = (m_idx == 4'd3) ? 4'd0 : m_idx + 4'd1;
        end
    end else if (go_left) begin
        if (m_idx == 4'd0) begin
            m_idx = uno_pkg::DRAW_SLOT;
        end else if (m_idx == uno_pkg::DRAW_SLOT) begin
            m_idx = uno_pkg::hand_idx_t'(last);
        end else begin
            m_idx = m_idx - 4'd1;
        end
    end else begin
        if (m_idx == uno_pkg::DRAW_SLOT) begin
            m_idx = '0;
        end else if (int'(m_idx) == last) begin
            m_idx = uno_pkg::DRAW_SLOT;
        end else begin
            m_idx = m_idx + 4'd1;
        end
    end
    model_clamp();
endfunction

`endif

// ==== testbench/tb_uno_player.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_uno_player;

    localparam int ROUNDS         = 30;
    localparam int ROUND_CYCLES   = 200;   // worst case of one round
    localparam int STIM_CYCLES    = 10 + 4 * int'(uno_pkg::DEAL_COUNT) + ROUNDS * ROUND_CYCLES;
    localparam int TIMEOUT_CYCLES = 2 * STIM_CYCLES;

    logic                i_clk;
    logic                i_rst_n;
    uno_pkg::turn_req_t  i_turn;
    uno_pkg::card_t      i_prev_card;
    logic                i_left;
    logic                i_right;
    logic                i_select;
    logic                i_drawn;
    uno_pkg::card_t      i_drawn_card;
    logic                i_check;
    uno_pkg::card_t      o_hands [uno_pkg::HAND_MAX];
    uno_pkg::hand_idx_t  o_index;
    logic                o_draw;
    logic                o_out;
    uno_pkg::card_t      o_out_card;

    int errors = 0;
    int cycles = 0;

    `include "uno_model.svh"

    uno_player DUT (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_turn       (i_turn),
        .i_prev_card  (i_prev_card),
        .i_left       (i_left),
        .i_right      (i_right),
        .i_select     (i_select),
        .i_drawn      (i_drawn),
        .i_drawn_card (i_drawn_card),
        .i_check      (i_check),
        .o_hands      (o_hands),
        .o_index      (o_index),
        .o_draw       (o_draw),
        .o_out        (o_out),
        .o_out_card   (o_out_card)
    );

    initial begin
        i_clk = 1'b0;
        forever #50 i_clk = ~i_clk;
    end

    always @(posedge i_clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    task automatic flag_error(string msg);
        $display("[ERROR] %0t %s", $time, msg);
        errors++;
    endtask

    task automatic check_hands(string what);
        uno_pkg::card_t exp;
        for (int s = 0; s < uno_pkg::HAND_MAX; s++) begin
            exp = (s < m_hand.size()) ? m_hand[s] : uno_pkg::EMPTY_CARD;
            if (o_hands[s] !== exp) begin
                flag_error($sformatf("%s: slot %0d is %h, expected %h", what, s, o_hands[s], exp));
            end
        end
    endtask

    task automatic pulse_select();
        @(posedge i_clk);
        i_select <= 1'b1;
        @(posedge i_clk);
        i_select <= 1'b0;
    endtask

    task automatic pulse_check();
        @(posedge i_clk);
        i_check <= 1'b1;
        @(posedge i_clk);
        i_check <= 1'b0;
    endtask

    task automatic deliver(uno_pkg::card_t c);
        @(posedge i_clk);
        i_drawn      <= 1'b1;
        i_drawn_card <= c;
        @(posedge i_clk);
        i_drawn <= 1'b0;
    endtask

    // press, hold two cycles, release
    task automatic press(bit go_left);
        @(posedge i_clk);
        if (go_left) begin
            i_left <= 1'b1;
        end else begin
            i_right <= 1'b1;
        end
        repeat (2) @(posedge i_clk);
        i_left  <= 1'b0;
        i_right <= 1'b0;
        @(posedge i_clk);
        cursor_step(go_left);
        @(negedge i_clk);
        if (o_index !== m_idx) begin
            flag_error($sformatf("cursor at %0d, expected %0d", o_index, m_idx));
        end
    endtask

    task automatic move_to(uno_pkg::hand_idx_t target);
        bit go_left;
        int guard = 0;
        go_left = (rand_below(2) == 1);
        while (m_idx != target && guard < 17) begin
            press(go_left);
            guard++;
        end
    endtask

    task automatic deal_cards(int n);
        uno_pkg::card_t c;
        for (int k = 0; k < n; k++) begin
            c = random_card();
            deliver(c);
            model_insert(c);
            repeat (2) @(negedge i_clk);
            check_hands("deal");
        end
    endtask

    task automatic penalty(bit four);
        @(posedge i_clk);
        i_turn.start     <= 1'b1;   // held, so the controller goes on to play
        i_turn.draw_two  <= !four;
        i_turn.draw_four <= four;
        deal_cards(four ? 4 : 2);
        @(posedge i_clk);
        i_turn <= '0;
    endtask

    task automatic draw_card();
        uno_pkg::card_t c;
        int hold;
        c = random_card();
        hold = rand_below(4);
        pulse_select();
        @(negedge i_clk);
        if (o_draw !== 1'b1) begin
            flag_error("o_draw not raised after selecting the draw slot");
        end
        repeat (hold) begin
            @(negedge i_clk);
            if (o_draw !== 1'b1) begin
                flag_error("o_draw dropped before i_drawn");
            end
        end
        deliver(c);
        model_insert(c);
        @(negedge i_clk);
        if (o_draw !== 1'b0) begin
            flag_error("o_draw still high after i_drawn");
        end
        @(negedge i_clk);
        check_hands("single draw");
        pulse_check();
    endtask

    task automatic play_turn();
        uno_pkg::card_t prev;
        uno_pkg::card_t c;
        int cnt;
        int t;
        cnt = m_hand.size();
        prev = {2'(rand_below(4)), 4'(rand_below(13))};
        if (cnt == 0 || (cnt < uno_pkg::HAND_MAX && rand_below(5) == 0)) begin
            t = int'(uno_pkg::DRAW_SLOT);
        end else begin
            t = rand_below(cnt);
        end
        // nearly full hand, make the pick playable
        if (cnt >= 13 && t != int'(uno_pkg::DRAW_SLOT) && !is_wild(m_hand[t])) begin
            prev = {m_hand[t][5:4], 4'(rand_below(13))};
        end
        @(posedge i_clk);
        i_prev_card <= prev;
        move_to(uno_pkg::hand_idx_t'(t));
        if (t == int'(uno_pkg::DRAW_SLOT)) begin
            draw_card();
        end else begin
            c = m_hand[t];
            pulse_select();
            if (is_wild(c)) begin
                m_color = 1'b1;
                model_remove(t);
                m_idx = '0;
                repeat (2) @(negedge i_clk);
                if (o_out !== 1'b0) begin
                    flag_error("o_out raised before the wild colour was chosen");
                end
                check_hands("wild play");
                press(1'b0);
                press(1'b0);
                pulse_select();
                m_color = 1'b0;
                m_idx = '0;
                model_clamp();
                @(negedge i_clk);
                if (o_out !== 1'b1 || o_out_card !== {2'd2, c[3:0]}) begin
                    flag_error($sformatf("wild offer out=%b card=%h, expected card %h",
                                         o_out, o_out_card, {2'd2, c[3:0]}));
                end
                pulse_check();
            end else if (card_legal(c, prev)) begin
                model_remove(t);
                @(negedge i_clk);
                if (o_out !== 1'b1 || o_out_card !== c) begin
                    flag_error($sformatf("offer out=%b card=%h, expected card %h",
                                         o_out, o_out_card, c));
                end
                @(negedge i_clk);
                check_hands("legal play");
                pulse_check();
            end else begin
                repeat (2) begin
                    @(negedge i_clk);
                    if (o_out !== 1'b0) begin
                        flag_error($sformatf("illegal card %h on %h was offered", c, prev));
                    end
                end
                check_hands("illegal select");
                move_to(uno_pkg::DRAW_SLOT);
                draw_card();
            end
        end
        @(negedge i_clk);
        if (o_out !== 1'b0 || o_draw !== 1'b0) begin
            flag_error("o_out or o_draw still high at the end of the turn");
        end
        if (o_index !== m_idx) begin
            flag_error($sformatf("cursor at %0d after the turn, expected %0d", o_index, m_idx));
        end
    endtask

    initial begin
        i_rst_n      = 1'b0;
        i_turn       = '0;
        i_prev_card  = '0;
        i_left       = 1'b0;
        i_right      = 1'b0;
        i_select     = 1'b0;
        i_drawn      = 1'b0;
        i_drawn_card = '0;
        i_check      = 1'b0;
        repeat (3) @(posedge i_clk);
        @(negedge i_clk);
        if (o_out !== 1'b0 || o_draw !== 1'b0 || o_index !== '0 || o_out_card !== '0) begin
            flag_error("outputs not cleared in reset");
        end
        check_hands("reset");
        @(posedge i_clk);
        i_rst_n <= 1'b1;
        model_clamp();   // empty hand parks the cursor on the draw slot

        @(posedge i_clk);
        i_turn.init <= 1'b1;
        @(posedge i_clk);
        i_turn.init <= 1'b0;
        deal_cards(int'(uno_pkg::DEAL_COUNT));

        for (int r = 0; r < ROUNDS; r++) begin
            if (m_hand.size() > 0) begin
                repeat (rand_below(4)) press(rand_below(2) == 1);
            end
            if (m_hand.size() <= 9 && rand_below(2) == 0) begin
                penalty(rand_below(2) == 1);
            end else begin
                @(posedge i_clk);
                i_turn.start <= 1'b1;
                @(posedge i_clk);
                i_turn.start <= 1'b0;
            end
            play_turn();
        end

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
